// File: rtl/ws28xx_pkg.sv
/* WS28xx controller definitions */
package ws28xx_pkg;

    // Host bus.
    localparam int addr_width = 12;
    localparam int data_width = 32;

    // Pixel storage and serial format.
    localparam int pix_depth    = 256;
    localparam int pixel_width  = 24;
    localparam int latch_cycles = 64;

    // Pixel FIFO between reader and encoder.
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

    typedef logic [$clog2(pix_depth)-1:0] pix_idx_t;
    typedef logic [pixel_width-1:0]       pixel_t;
    typedef logic [7:0]                   bit_time_t;

    typedef enum logic [1:0] {
        ctrl0 = 2'd0,
        ctrl1 = 2'd1,
        ctrl2 = 2'd2,
        count = 2'd3
    } reg_idx_t;

    // Same layout as the ctrl2 register.
    typedef struct packed {
        bit_time_t t1l;
        bit_time_t t1h;
        bit_time_t t0l;
        bit_time_t t0h;
    } timing_t;

    typedef struct packed {
        logic     en;
        pix_idx_t addr;
        pixel_t   data;
    } pix_wr_t;

endpackage

// File: rtl/ws28xx_pixel_ram.sv
/* Pixel memory */
`timescale 1ns/1ps

module ws28xx_pixel_ram (
    input  logic                 clk_i,

    input  ws28xx_pkg::pix_wr_t  wr_i,

    input  logic                 rd_en_i,
    input  ws28xx_pkg::pix_idx_t rd_addr_i,
    output ws28xx_pkg::pixel_t   rd_data_o
);

    ws28xx_pkg::pixel_t mem [ws28xx_pkg::pix_depth];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // Output holds the last word read while rd_en_i is low.
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: rtl/ws28xx_mmio.sv
/* WS28xx register block */
`timescale 1ns/1ps

module ws28xx_mmio (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  logic                                wr_en_i,
    input  logic [ws28xx_pkg::addr_width-1:0]   wr_addr_i,
    input  logic [ws28xx_pkg::data_width-1:0]   wr_data_i,

    input  logic                                rd_en_i,
    input  logic [ws28xx_pkg::addr_width-1:0]   rd_addr_i,
    output logic [ws28xx_pkg::data_width-1:0]   rd_data_o,

    input  logic                                frame_done_i,

    output ws28xx_pkg::pix_wr_t                 pix_wr_o,
    output ws28xx_pkg::timing_t                 timing_o,
    output ws28xx_pkg::pix_idx_t                count_o,
    output logic                                run_o,
    output logic                                start_o
);

    ws28xx_pkg::reg_idx_t wr_idx;
    ws28xx_pkg::reg_idx_t rd_idx;
    ws28xx_pkg::timing_t  timing_q;
    ws28xx_pkg::pix_idx_t count_q;
    logic                 run_q;
    logic                 sync_q;
    logic                 sync_prev_q;
    logic                 done_q;
    logic                 frame_done_q;
    logic                 reg_wr;
    logic                 sync_wr;
    logic [ws28xx_pkg::data_width-1:0] rd_mux;

    assign wr_idx  = ws28xx_pkg::reg_idx_t'(wr_addr_i[3:2]);
    assign rd_idx  = ws28xx_pkg::reg_idx_t'(rd_addr_i[3:2]);
    assign reg_wr  = wr_en_i && !wr_addr_i[10];
    assign sync_wr = reg_wr && wr_idx == ws28xx_pkg::ctrl1 && wr_data_i[0];

    // Address bit 10 selects the pixel memory.
    assign pix_wr_o.en   = wr_en_i && wr_addr_i[10];
    assign pix_wr_o.addr = wr_addr_i[9:2];
    assign pix_wr_o.data = wr_data_i[ws28xx_pkg::pixel_width-1:0];

    always_comb begin
        rd_mux = '0;
        case (rd_idx)
            ws28xx_pkg::ctrl0: begin
                rd_mux[ws28xx_pkg::data_width-1] = done_q;
                rd_mux[0]                        = run_q;
            end
            ws28xx_pkg::ctrl1: rd_mux[0] = sync_q;
            ws28xx_pkg::ctrl2: rd_mux = timing_q;
            default:           rd_mux[$bits(count_q)-1:0] = count_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o    <= '0;
            timing_q     <= '0;
            count_q      <= '0;
            run_q        <= 1'b0;
            sync_q       <= 1'b0;
            sync_prev_q  <= 1'b0;
            done_q       <= 1'b0;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= frame_done_i;
            sync_prev_q  <= sync_q;
            if (rd_en_i) begin
                rd_data_o <= rd_mux;
            end
            if (reg_wr) begin
                case (wr_idx)
                    ws28xx_pkg::ctrl0: run_q    <= wr_data_i[0];
                    ws28xx_pkg::ctrl2: timing_q <= wr_data_i;
                    ws28xx_pkg::count: count_q  <= wr_data_i[$bits(count_q)-1:0];
                    default: begin
                    end
                endcase
            end
            // Sync only takes effect while the pipeline runs.
            if (!run_q) begin
                sync_q <= 1'b0;
            end else if (sync_wr) begin
                sync_q <= 1'b1;
            end else if (frame_done_q) begin
                sync_q <= 1'b0;
            end
            if (sync_wr) begin
                done_q <= 1'b0;
            end else if (frame_done_q) begin
                done_q <= 1'b1;
            end
        end
    end

    assign start_o  = sync_q && !sync_prev_q;
    assign run_o    = run_q;
    assign timing_o = timing_q;
    assign count_o  = count_q;

    // A frame starts only once run has been stable for a cycle.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(start_o) |-> run_o && $past(run_o));

endmodule

// File: rtl/ws28xx_frame_reader.sv
/* Frame pixel reader */
`timescale 1ns/1ps

module ws28xx_frame_reader (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 clear_i,

    input  logic                 start_i,
    input  ws28xx_pkg::pix_idx_t count_i,

    output logic                 ram_rd_en_o,
    output ws28xx_pkg::pix_idx_t ram_addr_o,
    input  ws28xx_pkg::pixel_t   ram_data_i,

    output logic                 valid_o,
    input  logic                 ready_i,
    output ws28xx_pkg::pixel_t   pixel_o,
    output logic                 last_o
);

    typedef enum logic [1:0] {
        idle,
        fetch,
        offer
    } state_t;

    state_t               state_q;
    ws28xx_pkg::pix_idx_t addr_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= idle;
            addr_q  <= '0;
        end else if (clear_i) begin
            state_q <= idle;
            addr_q  <= '0;
        end else begin
            case (state_q)
                idle: begin
                    if (start_i) begin
                        addr_q  <= '0;
                        state_q <= fetch;
                    end
                end
                fetch: state_q <= offer;
                offer: begin
                    if (ready_i) begin
                        if (last_o) begin
                            state_q <= idle;
                        end else begin
                            addr_q  <= addr_q + 1'b1;
                            state_q <= fetch;
                        end
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    assign ram_rd_en_o = state_q == fetch;
    assign ram_addr_o  = addr_q;
    assign valid_o     = state_q == offer;
    // Memory output is stable until the next fetch.
    assign pixel_o     = ram_data_i;
    assign last_o      = addr_q == count_i;

endmodule

// File: rtl/ws28xx_pixel_fifo.sv
/* Pixel FIFO */
`timescale 1ns/1ps

module ws28xx_pixel_fifo (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               clear_i,

    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  ws28xx_pkg::pixel_t in_pixel_i,
    input  logic               in_last_i,

    output logic               out_valid_o,
    input  logic               out_ready_i,
    output ws28xx_pkg::pixel_t out_pixel_o,
    output logic               out_last_o
);

    logic [ws28xx_pkg::pixel_width:0]      mem [ws28xx_pkg::fifo_depth];
    logic [ws28xx_pkg::fifo_ptr_width-1:0] wr_ptr_q;
    logic [ws28xx_pkg::fifo_ptr_width-1:0] rd_ptr_q;
    logic [ws28xx_pkg::fifo_cnt_width-1:0] occ_q;
    logic                                  push;
    logic                                  pop;

    function automatic logic [ws28xx_pkg::fifo_ptr_width-1:0] next_ptr(
        input logic [ws28xx_pkg::fifo_ptr_width-1:0] ptr
    );
        return (ptr == ws28xx_pkg::fifo_depth - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o  = occ_q < ws28xx_pkg::fifo_depth;
    assign out_valid_o = occ_q != '0;
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    assign {out_last_o, out_pixel_o} = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= {in_last_i, in_pixel_i};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                occ_q <= occ_q + 1'b1;
            end else if (pop && !push) begin
                occ_q <= occ_q - 1'b1;
            end
        end
    end

    // Occupancy never leaves the range 0 to fifo_depth.
    assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        occ_q <= ws28xx_pkg::fifo_depth);
    // Pointers meet when the FIFO is empty or full.
    assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        (occ_q == '0 || occ_q == ws28xx_pkg::fifo_depth) |-> wr_ptr_q == rd_ptr_q);

endmodule

// File: rtl/ws28xx_bit_encoder.sv
/* WS28xx bit encoder */
`timescale 1ns/1ps

module ws28xx_bit_encoder (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                clear_i,

    input  ws28xx_pkg::timing_t timing_i,

    input  logic                valid_i,
    output logic                ready_o,
    input  ws28xx_pkg::pixel_t  pixel_i,
    input  logic                last_i,

    output logic                line_o,
    output logic                frame_done_o
);

    typedef enum logic [1:0] {
        idle,
        high,
        low,
        latch
    } state_t;

    state_t                state_q;
    ws28xx_pkg::pixel_t    shift_q;
    logic                  last_q;
    logic [$clog2(ws28xx_pkg::pixel_width)-1:0] bit_q;
    ws28xx_pkg::bit_time_t cnt_q;
    ws28xx_pkg::bit_time_t th_end;
    ws28xx_pkg::bit_time_t tl_end;
    logic                  pixel_end;
    logic                  low_end;
    logic                  take;
    logic                  done_q;

    // Pulse lengths follow the bit at the top of the shifter.
    assign th_end = (shift_q[ws28xx_pkg::pixel_width-1] ? timing_i.t1h : timing_i.t0h) - 8'd1;
    assign tl_end = (shift_q[ws28xx_pkg::pixel_width-1] ? timing_i.t1l : timing_i.t0l) - 8'd1;

    assign pixel_end = bit_q == ws28xx_pkg::pixel_width - 1;
    assign low_end   = state_q == low && cnt_q == tl_end;
    assign ready_o   = state_q == idle || (low_end && pixel_end && !last_q);
    assign take      = valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= idle;
            last_q  <= 1'b0;
            bit_q   <= '0;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else if (clear_i) begin
            state_q <= idle;
            last_q  <= 1'b0;
            bit_q   <= '0;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (take) begin
                shift_q <= pixel_i;
                last_q  <= last_i;
                bit_q   <= '0;
                cnt_q   <= '0;
                state_q <= high;
            end else begin
                case (state_q)
                    high: begin
                        if (cnt_q == th_end) begin
                            cnt_q   <= '0;
                            state_q <= low;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    low: begin
                        if (cnt_q != tl_end) begin
                            cnt_q <= cnt_q + 1'b1;
                        end else if (!pixel_end) begin
                            shift_q <= shift_q << 1;
                            bit_q   <= bit_q + 1'b1;
                            cnt_q   <= '0;
                            state_q <= high;
                        end else if (last_q) begin
                            cnt_q   <= '0;
                            state_q <= latch;
                        end
                        // Else the low time stretches until a pixel arrives.
                    end
                    latch: begin
                        if (cnt_q == ws28xx_pkg::bit_time_t'(ws28xx_pkg::latch_cycles - 1)) begin
                            cnt_q   <= '0;
                            done_q  <= 1'b1;
                            state_q <= idle;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    default: state_q <= idle;
                endcase
            end
        end
    end

    assign line_o       = state_q == high;
    assign frame_done_o = done_q;

    // Host timing must stay usable for the whole frame.
    assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        state_q != idle |-> timing_i.t0h != '0 && timing_i.t0l != '0 &&
                            timing_i.t1h != '0 && timing_i.t1l != '0);

endmodule

// File: rtl/ws28xx_ctrl.sv
/* WS28xx LED controller */
`timescale 1ns/1ps

module ws28xx_ctrl (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic                              wr_en_i,
    input  logic [ws28xx_pkg::addr_width-1:0] wr_addr_i,
    input  logic [ws28xx_pkg::data_width-1:0] wr_data_i,

    input  logic                              rd_en_i,
    input  logic [ws28xx_pkg::addr_width-1:0] rd_addr_i,
    output logic [ws28xx_pkg::data_width-1:0] rd_data_o,

    output logic                              line_o
);

    ws28xx_pkg::pix_wr_t  pix_wr;
    ws28xx_pkg::timing_t  timing;
    ws28xx_pkg::pix_idx_t count;
    logic                 run;
    logic                 start;
    logic                 frame_done;

    logic                 ram_rd_en;
    ws28xx_pkg::pix_idx_t ram_addr;
    ws28xx_pkg::pixel_t   ram_data;

    logic                 rdr_valid;
    logic                 rdr_ready;
    ws28xx_pkg::pixel_t   rdr_pixel;
    logic                 rdr_last;

    logic                 enc_valid;
    logic                 enc_ready;
    ws28xx_pkg::pixel_t   enc_pixel;
    logic                 enc_last;

    ws28xx_mmio i_mmio (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wr_en_i      (wr_en_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .rd_en_i      (rd_en_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .frame_done_i (frame_done),
        .pix_wr_o     (pix_wr),
        .timing_o     (timing),
        .count_o      (count),
        .run_o        (run),
        .start_o      (start)
    );

    ws28xx_pixel_ram i_pixel_ram (
        .clk_i     (clk_i),
        .wr_i      (pix_wr),
        .rd_en_i   (ram_rd_en),
        .rd_addr_i (ram_addr),
        .rd_data_o (ram_data)
    );

    // Clearing run holds the pixel pipeline in reset.
    ws28xx_frame_reader i_frame_reader (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (!run),
        .start_i     (start),
        .count_i     (count),
        .ram_rd_en_o (ram_rd_en),
        .ram_addr_o  (ram_addr),
        .ram_data_i  (ram_data),
        .valid_o     (rdr_valid),
        .ready_i     (rdr_ready),
        .pixel_o     (rdr_pixel),
        .last_o      (rdr_last)
    );

    ws28xx_pixel_fifo i_pixel_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (!run),
        .in_valid_i  (rdr_valid),
        .in_ready_o  (rdr_ready),
        .in_pixel_i  (rdr_pixel),
        .in_last_i   (rdr_last),
        .out_valid_o (enc_valid),
        .out_ready_i (enc_ready),
        .out_pixel_o (enc_pixel),
        .out_last_o  (enc_last)
    );

    ws28xx_bit_encoder i_bit_encoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clear_i      (!run),
        .timing_i     (timing),
        .valid_i      (enc_valid),
        .ready_o      (enc_ready),
        .pixel_i      (enc_pixel),
        .last_i       (enc_last),
        .line_o       (line_o),
        .frame_done_o (frame_done)
    );

endmodule

// File: tb/ws28xx_line_checker.sv
/* Serial line checker */
`timescale 1ns/1ps

module ws28xx_line_checker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                line_i,
    input  logic                arm_i,
    input  ws28xx_pkg::timing_t timing_i,
    input  int unsigned         npix_i,
    input  ws28xx_pkg::pixel_t  exp_pix_i [ws28xx_pkg::pix_depth],
    output logic                done_o,
    output int unsigned         pix_cnt_o,
    output int unsigned         err_cnt_o
);

    int unsigned        hi_run;
    int unsigned        lo_run;
    int unsigned        bit_cnt;
    int unsigned        err_cnt;
    logic               prev_bit;
    logic               done;
    ws28xx_pkg::pixel_t shift;

    // Threshold sits halfway between t0h and t1h.
    function automatic logic classify_bit(input int unsigned hi);
        int unsigned sum;
        sum = timing_i.t0h + timing_i.t1h;
        if (timing_i.t1h > timing_i.t0h) begin
            return hi * 2 > sum;
        end
        return hi * 2 < sum;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic flag_line_fault(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic clear_frame();
        hi_run   = 0;
        lo_run   = 0;
        bit_cnt  = 0;
        prev_bit = 1'b0;
        done     = 1'b0;
        shift    = '0;
    endtask

    // Line is sampled at each rising edge, one sample per cycle.
    always @(posedge clk_i or negedge rst_n_i) begin : watch
        logic        bit_val;
        int unsigned exp_t;
        int unsigned idx;
        if (!rst_n_i) begin
            clear_frame();
            err_cnt = 0;
        end else if (!arm_i) begin
            if (line_i) begin
                flag_line_fault("pulse on line_o while no frame is running");
            end
            clear_frame();
        end else if (line_i) begin
            if (done && hi_run == 0) begin
                flag_line_fault("pulse on line_o after the latch period");
            end else if (lo_run > 0) begin
                exp_t = prev_bit ? timing_i.t1l : timing_i.t0l;
                if (lo_run != exp_t) begin
                    report_mismatch($sformatf("bit %0d low for %0d cycles, expected %0d",
                                              bit_cnt - 1, lo_run, exp_t));
                end
            end
            lo_run = 0;
            hi_run++;
        end else if (hi_run > 0) begin
            bit_val = classify_bit(hi_run);
            exp_t   = bit_val ? timing_i.t1h : timing_i.t0h;
            if (hi_run != exp_t) begin
                report_mismatch($sformatf("bit %0d high for %0d cycles, expected %0d",
                                          bit_cnt, hi_run, exp_t));
            end
            shift    = {shift[ws28xx_pkg::pixel_width-2:0], bit_val};
            prev_bit = bit_val;
            bit_cnt++;
            hi_run = 0;
            lo_run = 1;
            if (bit_cnt % ws28xx_pkg::pixel_width == 0) begin
                idx = bit_cnt / ws28xx_pkg::pixel_width - 1;
                if (idx >= npix_i) begin
                    flag_line_fault("more pixels on line_o than the frame holds");
                end else if (shift != exp_pix_i[idx]) begin
                    report_mismatch($sformatf("pixel %0d is 0x%06h, expected 0x%06h",
                                              idx, shift, exp_pix_i[idx]));
                end
            end
        end else if (lo_run > 0) begin
            lo_run++;
        end
        // Frame ends once all bits are in and the line rests for the latch time.
        if (rst_n_i && arm_i && !done && bit_cnt == npix_i * ws28xx_pkg::pixel_width &&
            lo_run >= ws28xx_pkg::latch_cycles) begin
            done = 1'b1;
        end
    end

    assign done_o    = done;
    assign pix_cnt_o = bit_cnt / ws28xx_pkg::pixel_width;
    assign err_cnt_o = err_cnt;

endmodule

// File: tb/tb_ws28xx_ctrl.sv
/* WS28xx controller testbench */
`timescale 1ns/1ps

module tb_ws28xx_ctrl;

    localparam int n_tests       = 6;
    localparam int window_cycles = 400;

    typedef struct packed {
        ws28xx_pkg::bit_time_t t0h;
        ws28xx_pkg::bit_time_t t0l;
        ws28xx_pkg::bit_time_t t1h;
        ws28xx_pkg::bit_time_t t1l;
        logic [8:0]            npix;
        logic                  run;
        logic                  readback;
    } test_row_t;

    logic                              clk;
    logic                              rst_n;
    logic                              wr_en;
    logic [ws28xx_pkg::addr_width-1:0] wr_addr;
    logic [ws28xx_pkg::data_width-1:0] wr_data;
    logic                              rd_en;
    logic [ws28xx_pkg::addr_width-1:0] rd_addr;
    logic [ws28xx_pkg::data_width-1:0] rd_data;
    logic                              line;
    logic                              arm;
    ws28xx_pkg::timing_t               timing;
    int unsigned                       npix;
    ws28xx_pkg::pixel_t                exp_pix [ws28xx_pkg::pix_depth];
    logic                              chk_done;
    int unsigned                       chk_pix_cnt;
    int unsigned                       chk_err_cnt;
    int unsigned                       tb_errs;
    test_row_t                         rows [n_tests];

    ws28xx_ctrl i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .line_o    (line)
    );

    ws28xx_line_checker i_checker (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .line_i    (line),
        .arm_i     (arm),
        .timing_i  (timing),
        .npix_i    (npix),
        .exp_pix_i (exp_pix),
        .done_o    (chk_done),
        .pix_cnt_o (chk_pix_cnt),
        .err_cnt_o (chk_err_cnt)
    );

    always #5 clk = ~clk;

    function automatic logic [ws28xx_pkg::addr_width-1:0] reg_addr(
        input ws28xx_pkg::reg_idx_t idx
    );
        return {8'h00, idx, 2'b00};
    endfunction

    function automatic logic [ws28xx_pkg::addr_width-1:0] pix_addr(input int unsigned idx);
        return {2'b01, ws28xx_pkg::pix_idx_t'(idx), 2'b00};
    endfunction

    // Host accesses start and end on a falling edge.
    task automatic write_word(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic read_word(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en = 1'b0;
        data  = rd_data;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
            tb_errs++;
        end
    endtask

    task automatic wait_frame_done(input int unsigned limit, output logic ok);
        logic [31:0] rdata;
        ok = 1'b0;
        for (int unsigned i = 0; i < limit && !ok; i++) begin
            read_word(reg_addr(ws28xx_pkg::ctrl0), rdata);
            ok = rdata[31];
        end
    endtask

    initial begin : main
        test_row_t            row;
        logic [31:0]          rdata;
        ws28xx_pkg::pix_idx_t count_val;
        int unsigned          p0;
        int unsigned          p1;
        int unsigned          limit;
        int unsigned          tb_before;
        int unsigned          chk_before;
        int unsigned          pass_cnt;
        int unsigned          fail_cnt;
        logic                 ok;
        logic                 timed_out;
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        arm       = 1'b0;
        timing    = '0;
        npix      = 0;
        tb_errs   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        for (int i = 0; i < ws28xx_pkg::pix_depth; i++) begin
            exp_pix[i] = '0;
        end
        void'($urandom(32'h5de7_2928));

        // Columns are t0h, t0l, t1h, t1l, pixels, run, readback.
        rows[0] = '{8'd3, 8'd8, 8'd7, 8'd4, 9'd4, 1'b1, 1'b1};
        rows[1] = '{8'd1, 8'd1, 8'd2, 8'd1, 9'd1, 1'b1, 1'b0};
        rows[2] = '{8'd200, 8'd150, 8'd100, 8'd200, 9'd8, 1'b1, 1'b1};
        rows[3] = '{8'd2, 8'd5, 8'd5, 8'd2, 9'd8, 1'b1, 1'b0};
        rows[4] = '{8'd4, 8'd4, 8'd8, 8'd4, 9'd3, 1'b0, 1'b0};
        rows[5] = '{8'd1, 8'd200, 8'd200, 8'd1, 9'd2, 1'b1, 1'b1};

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int t = 0; t < n_tests && !timed_out; t++) begin
            row        = rows[t];
            tb_before  = tb_errs;
            chk_before = chk_err_cnt;
            count_val  = ws28xx_pkg::pix_idx_t'(row.npix - 9'd1);
            write_word(reg_addr(ws28xx_pkg::ctrl0), {31'd0, row.run});
            for (int unsigned p = 0; p < row.npix; p++) begin
                exp_pix[p] = ws28xx_pkg::pixel_t'($urandom);
                write_word(pix_addr(p), {8'h00, exp_pix[p]});
            end
            timing = '{t1l: row.t1l, t1h: row.t1h, t0l: row.t0l, t0h: row.t0h};
            npix   = row.npix;
            write_word(reg_addr(ws28xx_pkg::ctrl2), timing);
            write_word(reg_addr(ws28xx_pkg::count), {24'h0, count_val});
            if (row.run) begin
                arm = 1'b1;
                write_word(reg_addr(ws28xx_pkg::ctrl1), 32'd1);
                if (row.readback) begin
                    read_word(reg_addr(ws28xx_pkg::ctrl2), rdata);
                    check_value("ctrl2", rdata, timing);
                    read_word(reg_addr(ws28xx_pkg::count), rdata);
                    check_value("count", rdata, {24'h0, count_val});
                    read_word(reg_addr(ws28xx_pkg::ctrl0), rdata);
                    check_value("ctrl0 after sync", rdata, 32'h0000_0001);
                end
                p0    = row.t0h + row.t0l;
                p1    = row.t1h + row.t1l;
                limit = row.npix * ws28xx_pkg::pixel_width * (p0 > p1 ? p0 : p1) +
                        ws28xx_pkg::latch_cycles + 100;
                wait_frame_done(limit, ok);
                if (!ok) begin
                    $display("ERROR at %0t: test %0d timed out waiting for done", $time, t);
                    timed_out = 1'b1;
                end else begin
                    read_word(reg_addr(ws28xx_pkg::ctrl1), rdata);
                    check_value("ctrl1 after frame", rdata, 32'h0);
                    check_value("decoded pixel count", chk_pix_cnt, row.npix);
                    if (!chk_done) begin
                        $display("ERROR at %0t: line_o never showed the latch period", $time);
                        tb_errs++;
                    end
                end
                arm = 1'b0;
            end else begin
                // Checker flags any pulse on the line while it is not armed.
                write_word(reg_addr(ws28xx_pkg::ctrl1), 32'd1);
                for (int c = 0; c < window_cycles; c++) begin
                    @(negedge clk);
                end
                read_word(reg_addr(ws28xx_pkg::ctrl0), rdata);
                check_value("ctrl0 while disabled", rdata, 32'h0);
                read_word(reg_addr(ws28xx_pkg::ctrl1), rdata);
                check_value("ctrl1 while disabled", rdata, 32'h0);
            end
            if (tb_errs == tb_before && chk_err_cnt == chk_before && !timed_out) begin
                pass_cnt++;
                $display("test %0d: ok, %0d pixel(s) on the line", t, chk_pix_cnt);
            end else begin
                fail_cnt++;
                $display("test %0d: errors, %0d pixel(s) on the line", t, chk_pix_cnt);
            end
        end

        $display("%0d test(s) ok, %0d test(s) with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: ws28xx_ctrl.f
rtl/ws28xx_pkg.sv
rtl/ws28xx_pixel_ram.sv
rtl/ws28xx_mmio.sv
rtl/ws28xx_frame_reader.sv
rtl/ws28xx_pixel_fifo.sv
rtl/ws28xx_bit_encoder.sv
rtl/ws28xx_ctrl.sv
tb/ws28xx_line_checker.sv
tb/tb_ws28xx_ctrl.sv

// File: Bender.yml
package:
  name: ws28xx_ctrl

sources:
  # Package first, then the RTL blocks and the top level.
  - rtl/ws28xx_pkg.sv
  - rtl/ws28xx_pixel_ram.sv
  - rtl/ws28xx_mmio.sv
  - rtl/ws28xx_frame_reader.sv
  - rtl/ws28xx_pixel_fifo.sv
  - rtl/ws28xx_bit_encoder.sv
  - rtl/ws28xx_ctrl.sv

  - target: test
    files:
      - tb/ws28xx_line_checker.sv
      - tb/tb_ws28xx_ctrl.sv
